// File: Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mem_subsystem
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# a failing run ends in \$$fatal, so the binary exits nonzero and make fails
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/backing_memory.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_ctrl_config.svh"

module backing_memory (
	input wire clock_cntrl_i,
	input wire reset_i,
	input wire mem_req_i,	// strobe
	input wire mem_ctrl_pkg::mem_req_t mem_mreq_i,
	output logic mem_done_o,
	output mem_ctrl_pkg::data_t mem_data_o
);

	import mem_ctrl_pkg::*;

	localparam int WORDS = 1 << `BW_WORD_ADDR;
	localparam int CNT_W = $clog2(`MEM_LATENCY) + 1;

	data_t mem [WORDS];
	logic [WORDS-1:0] written;	// never written words read the pattern
	mem_req_t cur;	// request in service
	logic pend;
	logic [CNT_W-1:0] cnt;
	logic finish;

	assign finish = pend && (cnt == '0);

	// ------------------------------------------------------------
	// latency counter
	// ------------------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			pend <= 1'b0;
			cnt <= '0;
			mem_done_o <= 1'b0;
			written <= '0;
		end else begin
			mem_done_o <= 1'b0;
			if (mem_req_i && !pend) begin
				pend <= 1'b1;
				cnt <= CNT_W'(`MEM_LATENCY - 2);	// done is registered, one more cycle
			end else if (finish) begin
				pend <= 1'b0;
				mem_done_o <= 1'b1;	// single cycle
				if (cur.rw)
					written[cur.addr] <= 1'b1;
			end else if (pend) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// array and read data
	always_ff @(posedge clock_cntrl_i) begin
		if (mem_req_i && !pend)
			cur <= mem_mreq_i;
		if (finish) begin
			if (cur.rw)
				mem[cur.addr] <= cur.data;
			else if (written[cur.addr])
				mem_data_o <= mem[cur.addr];
			else
				mem_data_o <= data_t'(cur.addr) ^ 32'h5a5a0000;	// default pattern
		end
	end

endmodule

`default_nettype wire

// File: rtl/line_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_ctrl_config.svh"

module line_cache (
	input wire clock_cntrl_i,
	input wire reset_i,

	// core side
	input wire core_req_i,	// level, held until done
	input wire core_rw_i,
	input wire mem_ctrl_pkg::word_addr_t core_addr_i,
	input wire mem_ctrl_pkg::data_t core_data_i,
	output mem_ctrl_pkg::data_t core_data_o,
	output logic core_done_o,

	// controller side
	output logic mem_req_o,	// held until accept
	output mem_ctrl_pkg::mem_req_t mem_req_struct_o,
	input wire accept_i,
	input wire rd_valid_i,
	input wire mem_ctrl_pkg::data_t rd_data_i
);

	import mem_ctrl_pkg::*;

	localparam int IDX_W = $clog2(`CACHE_LINES);
	localparam int TAG_W = `BW_WORD_ADDR - IDX_W;

	// ------------------------------------------------------------
	// line storage
	// ------------------------------------------------------------
	logic [TAG_W-1:0] tag_arr [`CACHE_LINES];
	data_t data_arr [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid;

	cache_state_t state;
	logic req_pend;	// strobe toward controller

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic hit;

	// direct mapped, low bits pick the line
	assign idx = core_addr_i[IDX_W-1:0];
	assign tag = core_addr_i[`BW_WORD_ADDR-1:IDX_W];
	assign hit = valid[idx] && (tag_arr[idx] == tag);

	assign core_done_o = (state == CACHE_DONE);	// single cycle state
	assign mem_req_o = req_pend;

	// core holds its request until done, so the struct stays stable
	assign mem_req_struct_o = '{rw: core_rw_i, addr: core_addr_i, data: core_data_i};

	// ------------------------------------------------------------
	// control fsm
	// ------------------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			state <= CACHE_IDLE;
			req_pend <= 1'b0;
			valid <= '0;
		end else begin
			case (state)
				CACHE_IDLE: begin
					if (core_req_i)
						state <= CACHE_LOOKUP;
				end
				CACHE_LOOKUP: begin
					if (core_rw_i) begin
						state <= CACHE_WRITE;	// write through, always to memory
						req_pend <= 1'b1;
					end else if (hit) begin
						state <= CACHE_DONE;
					end else begin
						state <= CACHE_MISS;
						req_pend <= 1'b1;
					end
				end
				CACHE_MISS: begin
					if (accept_i)
						req_pend <= 1'b0;
					if (rd_valid_i) begin	// fill arrives
						valid[idx] <= 1'b1;
						state <= CACHE_DONE;
					end
				end
				CACHE_WRITE: begin
					if (accept_i) begin	// buffer has it, core can go on
						req_pend <= 1'b0;
						state <= CACHE_DONE;
					end
				end
				CACHE_DONE: state <= CACHE_IDLE;	// req ignored here
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// data path
	// ------------------------------------------------------------
	always_ff @(posedge clock_cntrl_i) begin
		if (state == CACHE_LOOKUP && hit) begin
			if (core_rw_i)
				data_arr[idx] <= core_data_i;	// update hit line only
			else
				core_data_o <= data_arr[idx];	// read hit
		end
		if (state == CACHE_MISS && rd_valid_i) begin
			data_arr[idx] <= rd_data_i;
			tag_arr[idx] <= tag;
			core_data_o <= rd_data_i;	// return filled word
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_ctrl_config.svh
`ifndef MEM_CTRL_CONFIG_SVH
`define MEM_CTRL_CONFIG_SVH

// ------------------------------------------------------------
// address widths
// ------------------------------------------------------------
`define BW_BYTE_ADDR	12	// core byte address bits in use
`define BW_WORD_ADDR	10	// byte address minus the two low bits

// ------------------------------------------------------------
// sizes and timing
// ------------------------------------------------------------
`define CACHE_LINES	16	// one word per line
`define BUF_DEPTH	4	// request fifo entries
`define MEM_LATENCY	3	// request to done, in cycles

`endif

// File: rtl/mem_ctrl_pkg.sv
`default_nettype none

`include "mem_ctrl_config.svh"

package mem_ctrl_pkg;

	// basic vectors
	typedef logic [31:0] byte_addr_t;	// core view
	typedef logic [`BW_WORD_ADDR-1:0] word_addr_t;	// cache and memory view
	typedef logic [31:0] data_t;

	// core to controller
	typedef struct packed {
		logic rw;	// 1 = write
		byte_addr_t addr;
		data_t data;
	} core_req_t;

	// cache to controller to buffer to memory
	typedef struct packed {
		logic rw;	// 1 = write
		word_addr_t addr;
		data_t data;
	} mem_req_t;

	// [0] p0 hword, [1] p0 word, [2] p1 hword, [3] p1 word
	typedef logic [3:0] exc_t;

	typedef enum logic [2:0] {
		CACHE_IDLE,
		CACHE_LOOKUP,
		CACHE_MISS,
		CACHE_WRITE,
		CACHE_DONE
	} cache_state_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CACHE0,
		ARB_CACHE1
	} arb_state_t;

endpackage

`default_nettype wire

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top (
	input wire clock_cntrl_i,
	input wire reset_i,
	input wire core0_req_i,	// instruction port
	input wire core1_req_i,	// data port
	input wire mem_ctrl_pkg::core_req_t core0_i,
	input wire mem_ctrl_pkg::core_req_t core1_i,
	output mem_ctrl_pkg::data_t core0_data_o,
	output mem_ctrl_pkg::data_t core1_data_o,
	output logic core0_done_o,
	output logic core1_done_o,
	output mem_ctrl_pkg::exc_t exceptions_o
);

	import mem_ctrl_pkg::*;

	// ------------------------------------------------------------
	// cache <-> controller
	// ------------------------------------------------------------
	mem_req_t cache0_core, cache1_core;	// word addressed core requests
	logic cache0_req, cache1_req;
	mem_req_t cache0_mreq, cache1_mreq;
	logic cache0_accept, cache1_accept;
	logic cache0_rd_valid, cache1_rd_valid;
	data_t cache0_rd_data, cache1_rd_data;

	// controller <-> buffer <-> memory
	logic buf_req, buf_accept, buf_rd_valid;
	mem_req_t buf_mreq;
	data_t buf_rd_data;
	logic mem_req, mem_done;
	mem_req_t mem_mreq;
	data_t mem_data;

	line_cache i_cache0 (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.core_req_i(core0_req_i), .core_rw_i(cache0_core.rw),
		.core_addr_i(cache0_core.addr), .core_data_i(cache0_core.data),
		.core_data_o(core0_data_o), .core_done_o(core0_done_o),
		.mem_req_o(cache0_req), .mem_req_struct_o(cache0_mreq),
		.accept_i(cache0_accept), .rd_valid_i(cache0_rd_valid), .rd_data_i(cache0_rd_data)
	);

	line_cache i_cache1 (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.core_req_i(core1_req_i), .core_rw_i(cache1_core.rw),
		.core_addr_i(cache1_core.addr), .core_data_i(cache1_core.data),
		.core_data_o(core1_data_o), .core_done_o(core1_done_o),
		.mem_req_o(cache1_req), .mem_req_struct_o(cache1_mreq),
		.accept_i(cache1_accept), .rd_valid_i(cache1_rd_valid), .rd_data_i(cache1_rd_data)
	);

	memory_controller_internal i_ctrl (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.core0_req_i(core0_req_i), .core1_req_i(core1_req_i),
		.core0_i(core0_i), .core1_i(core1_i), .exceptions_o(exceptions_o),
		.cache0_core_o(cache0_core), .cache1_core_o(cache1_core),
		.cache0_req_i(cache0_req), .cache1_req_i(cache1_req),
		.cache0_mreq_i(cache0_mreq), .cache1_mreq_i(cache1_mreq),
		.cache0_accept_o(cache0_accept), .cache1_accept_o(cache1_accept),
		.cache0_rd_valid_o(cache0_rd_valid), .cache1_rd_valid_o(cache1_rd_valid),
		.cache0_rd_data_o(cache0_rd_data), .cache1_rd_data_o(cache1_rd_data),
		.buf_req_o(buf_req), .buf_mreq_o(buf_mreq), .buf_accept_i(buf_accept),
		.buf_rd_valid_i(buf_rd_valid), .buf_rd_data_i(buf_rd_data)
	);

	txrx_buffer i_buf (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.req_i(buf_req), .mreq_i(buf_mreq), .accept_o(buf_accept),
		.rd_valid_o(buf_rd_valid), .rd_data_o(buf_rd_data),
		.mem_req_o(mem_req), .mem_mreq_o(mem_mreq),
		.mem_done_i(mem_done), .mem_data_i(mem_data)
	);

	backing_memory i_mem (
		.clock_cntrl_i(clock_cntrl_i), .reset_i(reset_i),
		.mem_req_i(mem_req), .mem_mreq_i(mem_mreq),
		.mem_done_o(mem_done), .mem_data_o(mem_data)
	);

endmodule

`default_nettype wire

// File: rtl/memory_controller_internal.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_ctrl_config.svh"

module memory_controller_internal (
	input wire clock_cntrl_i,
	input wire reset_i,

	// core ports
	input wire core0_req_i,
	input wire core1_req_i,
	input wire mem_ctrl_pkg::core_req_t core0_i,
	input wire mem_ctrl_pkg::core_req_t core1_i,
	output mem_ctrl_pkg::exc_t exceptions_o,

	// to caches, word addressed
	output mem_ctrl_pkg::mem_req_t cache0_core_o,
	output mem_ctrl_pkg::mem_req_t cache1_core_o,

	// from caches
	input wire cache0_req_i,
	input wire cache1_req_i,
	input wire mem_ctrl_pkg::mem_req_t cache0_mreq_i,
	input wire mem_ctrl_pkg::mem_req_t cache1_mreq_i,

	// back to caches
	output logic cache0_accept_o,
	output logic cache1_accept_o,
	output logic cache0_rd_valid_o,
	output logic cache1_rd_valid_o,
	output mem_ctrl_pkg::data_t cache0_rd_data_o,
	output mem_ctrl_pkg::data_t cache1_rd_data_o,

	// buffer side
	output logic buf_req_o,
	output mem_ctrl_pkg::mem_req_t buf_mreq_o,
	input wire buf_accept_i,
	input wire buf_rd_valid_i,
	input wire mem_ctrl_pkg::data_t buf_rd_data_i
);

	import mem_ctrl_pkg::*;

	arb_state_t arb_state;
	logic grant0, grant1;
	logic sel_req;
	mem_req_t sel_mreq;
	logic release_grant;

	// ------------------------------------------------------------
	// alignment exceptions, flag only
	// ------------------------------------------------------------
	assign exceptions_o[0] = core0_req_i & core0_i.addr[0];	// hword
	assign exceptions_o[1] = core0_req_i & (|core0_i.addr[1:0]);	// word
	assign exceptions_o[2] = core1_req_i & core1_i.addr[0];
	assign exceptions_o[3] = core1_req_i & (|core1_i.addr[1:0]);

	// byte to word address, low two bits dropped
	assign cache0_core_o = '{rw: core0_i.rw, addr: core0_i.addr[`BW_BYTE_ADDR-1:2],
		data: core0_i.data};
	assign cache1_core_o = '{rw: core1_i.rw, addr: core1_i.addr[`BW_BYTE_ADDR-1:2],
		data: core1_i.data};

	// ------------------------------------------------------------
	// arbitration, port 0 first
	// ------------------------------------------------------------
	assign grant0 = (arb_state == ARB_CACHE0);
	assign grant1 = (arb_state == ARB_CACHE1);

	assign sel_req = grant0 ? cache0_req_i : (grant1 ? cache1_req_i : 1'b0);
	assign sel_mreq = grant1 ? cache1_mreq_i : cache0_mreq_i;

	// writes let go on accept, reads hold until their data is back
	assign release_grant = (sel_req && buf_accept_i && sel_mreq.rw) || buf_rd_valid_i;

	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			arb_state <= ARB_IDLE;
		end else begin
			case (arb_state)
				ARB_IDLE: begin
					if (cache0_req_i)
						arb_state <= ARB_CACHE0;
					else if (cache1_req_i)
						arb_state <= ARB_CACHE1;
				end
				ARB_CACHE0,
				ARB_CACHE1: begin
					if (release_grant)
						arb_state <= ARB_IDLE;
				end
				default: arb_state <= ARB_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// routing
	// ------------------------------------------------------------
	assign buf_req_o = sel_req;
	assign buf_mreq_o = sel_mreq;

	// non granted cache sees zeros
	assign cache0_accept_o = grant0 & buf_accept_i;
	assign cache1_accept_o = grant1 & buf_accept_i;
	assign cache0_rd_valid_o = grant0 & buf_rd_valid_i;
	assign cache1_rd_valid_o = grant1 & buf_rd_valid_i;
	assign cache0_rd_data_o = grant0 ? buf_rd_data_i : '0;
	assign cache1_rd_data_o = grant1 ? buf_rd_data_i : '0;

endmodule

`default_nettype wire

// File: rtl/txrx_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_ctrl_config.svh"

module txrx_buffer (
	input wire clock_cntrl_i,
	input wire reset_i,

	// controller side
	input wire req_i,	// strobe
	input wire mem_ctrl_pkg::mem_req_t mreq_i,
	output logic accept_o,
	output logic rd_valid_o,
	output mem_ctrl_pkg::data_t rd_data_o,

	// memory side
	output logic mem_req_o,
	output mem_ctrl_pkg::mem_req_t mem_mreq_o,
	input wire mem_done_i,
	input wire mem_ctrl_pkg::data_t mem_data_i
);

	import mem_ctrl_pkg::*;

	localparam int PTR_W = $clog2(`BUF_DEPTH);
	localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

	mem_req_t fifo [`BUF_DEPTH];	// head stays until memory is done with it
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic busy;	// one request outstanding
	logic full, empty;
	logic push, pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`BUF_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(`BUF_DEPTH));
	assign empty = (count == '0);

	// ------------------------------------------------------------
	// controller side
	// ------------------------------------------------------------
	assign accept_o = req_i && !full;	// same cycle
	assign push = accept_o;

	// ------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------
	assign mem_req_o = !busy && !empty;	// issue head
	assign mem_mreq_o = fifo[rd_ptr];
	assign pop = busy && mem_done_i;

	// completed writes just drop out
	assign rd_valid_o = pop && !fifo[rd_ptr].rw;
	assign rd_data_o = mem_data_i;

	always_ff @(posedge clock_cntrl_i) begin
		if (!reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			busy <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase

			if (mem_req_o)
				busy <= 1'b1;
			else if (pop)
				busy <= 1'b0;
		end
	end

	// entry storage
	always_ff @(posedge clock_cntrl_i) begin
		if (push)
			fifo[wr_ptr] <= mreq_i;
	end

endmodule

`default_nettype wire

// File: sim/mem_stimulus.txt
// port rw byte_addr write_data expected_read_data (all hex, rw 1 = write)
// port 0 stays below 0x800, port 1 at 0x800 and up; expected is unused for writes
0 0 00000040 00000000 5a5a0010
0 0 00000040 00000000 5a5a0010
0 1 00000040 cafe0001 00000000
0 0 00000040 00000000 cafe0001
0 1 00000100 12345678 00000000
0 0 00000100 00000000 12345678
0 0 00000040 00000000 cafe0001
0 0 000000a2 00000000 5a5a0028
0 0 000000a3 00000000 5a5a0028
0 1 000000a1 deadbeef 00000000
0 0 000000a0 00000000 deadbeef
0 0 000007fc 00000000 5a5a01ff
1 1 00000800 11110000 00000000
1 1 00000804 22220000 00000000
1 1 00000808 33330000 00000000
1 0 00000800 00000000 11110000
1 0 00000804 00000000 22220000
1 0 00000804 00000000 22220000
1 0 00000a40 00000000 5a5a0290
1 0 00000a41 00000000 5a5a0290
1 1 00000a42 44445555 00000000
1 0 00000a40 00000000 44445555
1 0 00000808 00000000 33330000
1 0 00000ffc 00000000 5a5a03ff

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_ctrl_config.svh"

module tb_mem_subsystem;

	import mem_ctrl_pkg::*;

	localparam int MAX_LINES = 64;	// records the stimulus array can hold
	localparam int WORDS = 1 << `BW_WORD_ADDR;
	localparam int HIT_LATENCY = 2;	// lookup, then done

	logic clock_cntrl;
	logic reset;
	logic core0_req, core1_req;
	core_req_t core0_s, core1_s;
	data_t core0_data, core1_data;
	logic core0_done, core1_done;
	exc_t exceptions;

	// five words per record: port, rw, byte address, write data, expected read data
	logic [31:0] stim [5*MAX_LINES];
	int n_lines;
	int gap [MAX_LINES];	// idle cycles ahead of each access
	int q0 [$];	// record numbers per port
	int q1 [$];
	integer seed;

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	data_t model_mem [WORDS];
	word_addr_t line_addr [2][`CACHE_LINES];	// which word each line holds
	bit line_valid [2][`CACHE_LINES];

	int cycle_cnt;
	int limit;
	int fd;

	mem_subsystem_top i_mem_subsystem_top (
		.clock_cntrl_i(clock_cntrl),
		.reset_i(reset),
		.core0_req_i(core0_req),
		.core1_req_i(core1_req),
		.core0_i(core0_s),
		.core1_i(core1_s),
		.core0_data_o(core0_data),
		.core1_data_o(core1_data),
		.core0_done_o(core0_done),
		.core1_done_o(core1_done),
		.exceptions_o(exceptions)
	);

	initial begin
		clock_cntrl = 1'b0;
		forever #5 clock_cntrl = ~clock_cntrl;	// 10 ns
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp)
			stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_exc(input string name, input exc_t exp, input exc_t act);
		if (act !== exp)
			stop_on_error($sformatf("mismatch %s exceptions: expected %b, actual %b",
				name, exp, act));
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp)
			stop_on_error($sformatf("mismatch %s hit latency: expected %0d, actual %0d",
				name, exp, act));
	endtask

	function automatic logic port_done(input int port);
		return (port == 0) ? core0_done : core1_done;
	endfunction

	function automatic data_t port_data(input int port);
		return (port == 0) ? core0_data : core1_data;
	endfunction

	function automatic exc_t port_mask(input int port);
		return (port == 0) ? 4'b0011 : 4'b1100;
	endfunction

	// halfword misaligned on bit 0 set, word misaligned on any low bit set
	function automatic exc_t expected_exc(input int port, input byte_addr_t addr);
		exc_t e;
		e = '0;
		e[2*port] = addr[0];
		e[2*port+1] = (addr[1:0] != 2'b00);
		return e;
	endfunction

	task automatic drive_port(input int port, input logic req, input core_req_t s);
		if (port == 0) begin
			core0_req <= req;
			core0_s <= s;
		end else begin
			core1_req <= req;
			core1_s <= s;
		end
	endtask

	// ------------------------------------------------------------
	// one port's access sequence
	// ------------------------------------------------------------
	task automatic run_port(input int port);
		int n;
		int idx;
		int line;
		int lat;
		logic rw;
		byte_addr_t addr;
		data_t wdata;
		data_t fexp;
		data_t act;
		word_addr_t waddr;
		bit hit;
		string name;
		core_req_t s;
		n = (port == 0) ? q0.size() : q1.size();
		for (int k = 0; k < n; k++) begin
			idx = (port == 0) ? q0[k] : q1[k];
			rw = stim[5*idx+1][0];
			addr = stim[5*idx+2];
			wdata = stim[5*idx+3];
			fexp = stim[5*idx+4];
			waddr = addr[`BW_BYTE_ADDR-1:2];	// low two bits dropped
			line = int'(waddr) % `CACHE_LINES;
			hit = line_valid[port][line] && (line_addr[port][line] == waddr);
			name = $sformatf("line %0d port %0d %s %h", idx, port, rw ? "write" : "read", addr);
			s = '{rw: rw, addr: addr, data: wdata};

			repeat (gap[idx]) @(posedge clock_cntrl);
			@(posedge clock_cntrl);
			drive_port(port, 1'b1, s);

			@(negedge clock_cntrl);
			check_exc(name, expected_exc(port, addr), exceptions & port_mask(port));
			lat = 0;	// edges counted from the one that samples req
			while (!port_done(port)) begin
				@(negedge clock_cntrl);
				lat++;
			end
			act = port_data(port);

			if (rw) begin
				model_mem[waddr] = wdata;	// write through, no allocate
			end else begin
				check_data(name, model_mem[waddr], act);
				check_data({name, " file"}, fexp, act);
				if (hit)
					check_cycles(name, HIT_LATENCY, lat);
				line_valid[port][line] = 1'b1;	// miss fills the line
				line_addr[port][line] = waddr;
			end

			@(posedge clock_cntrl);
			drive_port(port, 1'b0, '0);
			@(negedge clock_cntrl);
			if (port_done(port))
				stop_on_error($sformatf("%s: done stayed high for more than one cycle", name));
		end
	endtask

	// ------------------------------------------------------------
	// timeout
	// ------------------------------------------------------------
	always @(posedge clock_cntrl) begin
		cycle_cnt++;
		if (limit != 0 && cycle_cnt >= limit)
			stop_on_error($sformatf("timeout after %0d cycles, a request never got its done",
				cycle_cnt));
	end

	initial begin
		reset = 1'b0;
		core0_req = 1'b0;
		core1_req = 1'b0;
		core0_s = '0;
		core1_s = '0;
		seed = 32'hefd96b14;
		cycle_cnt = 0;
		limit = 0;

		fd = $fopen("sim/mem_stimulus.txt", "r");
		if (fd == 0)
			stop_on_error("could not open the stimulus file sim/mem_stimulus.txt");
		$fclose(fd);

		// port words above 1 mark the end of the records
		for (int i = 0; i < 5*MAX_LINES; i++)
			stim[i] = 32'hfff00000 | i;
		$readmemh("sim/mem_stimulus.txt", stim);

		n_lines = 0;
		while (n_lines < MAX_LINES && stim[5*n_lines] <= 1) begin
			if ((stim[5*n_lines] == 0) != (stim[5*n_lines+2] < 32'h800) ||
				stim[5*n_lines+2] >= 32'h1000)
				stop_on_error($sformatf("stimulus line %0d uses an address outside its port half",
					n_lines));
			if (stim[5*n_lines] == 0)
				q0.push_back(n_lines);
			else
				q1.push_back(n_lines);
			gap[n_lines] = {$random(seed)} % 4;
			n_lines++;
		end
		if (n_lines == 0)
			stop_on_error("the stimulus file holds no accesses");
		limit = n_lines * 40 + 100;

		// never written words read their address xor the pattern
		for (int i = 0; i < WORDS; i++)
			model_mem[i] = data_t'(i) ^ 32'h5a5a0000;
		for (int p = 0; p < 2; p++)
			for (int l = 0; l < `CACHE_LINES; l++)
				line_valid[p][l] = 1'b0;

		repeat (3) @(posedge clock_cntrl);
		reset <= 1'b1;

		fork
			run_port(0);
			run_port(1);
		join

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/mem_ctrl_pkg.sv
rtl/line_cache.sv
rtl/memory_controller_internal.sv
rtl/txrx_buffer.sv
rtl/backing_memory.sv
rtl/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv
